// File: source/sudoku_params.svh
`ifndef SUDOKU_PARAMS_SVH
`define SUDOKU_PARAMS_SVH

// Board geometry.
`define SUDOKU_N 9
`define SUDOKU_CELLS 81

// Width of one cell value, enough for 1..9.
`define CELL_W 4

// A visibility code of all ones marks a revealed cell.
`define VIS_W 2

// Game rules.
`define STRIKE_LIMIT 3
`define TIME_LIMIT_SECONDS 300 // Only checked on hard difficulty.

`endif

// File: source/sudoku_game_pkg.sv
`include "sudoku_params.svh"

package sudoku_game_pkg;

    // Seven states of one game round.
    typedef enum logic [2:0] {
        idle         = 3'd0,
        select_level = 3'd1,
        loading      = 3'd2,
        walk_map     = 3'd3,
        pick_number  = 3'd4,
        victory      = 3'd5,
        defeat       = 3'd6
    } game_state_t;

    // Cursor position, row 0 is the top of the grid.
    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } cell_pos_t;

    // Cell k sits at element k, with k = row * 9 + col.
    typedef logic [`SUDOKU_CELLS-1:0][`CELL_W-1:0] board_t;

    typedef logic [`SUDOKU_CELLS-1:0][`VIS_W-1:0] visibility_t;

endpackage

// File: source/sudoku_io_pkg.sv
package sudoku_io_pkg;

    // One-cycle pulses from the debounced buttons.
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic start;
        logic a;
        logic b;
    } buttons_t;

    typedef struct packed {
        logic [4:0] minutes;
        logic [5:0] seconds;
    } clock_time_t;

    // d0 is the rightmost digit and sits in the low bits.
    typedef struct packed {
        logic [3:0] d5;
        logic [3:0] d4;
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } digits_t;

endpackage

// File: source/game_fsm.sv
`timescale 1ns/1ps
`include "sudoku_params.svh"

module game_fsm (
    input  logic                         clk,
    input  logic                         reset,
    input  sudoku_io_pkg::buttons_t      buttons,
    input  sudoku_game_pkg::visibility_t visibility,
    input  logic                         cell_revealed,
    input  logic [`CELL_W-1:0]           cell_value,
    input  logic [`CELL_W-1:0]           candidate,
    input  logic [1:0]                   strikes,
    input  logic [10:0]                  timer,
    output sudoku_game_pkg::game_state_t state,
    output logic                         difficulty
);

    sudoku_game_pkg::game_state_t next_state;
    logic playing;
    logic victory_cond;
    logic defeat_cond;

    // Win and loss only count while a round is in progress, so stale board
    // contents or timer values cannot end a game that has not started yet.
    assign playing = (state == sudoku_game_pkg::walk_map) ||
                     (state == sudoku_game_pkg::pick_number);

    assign victory_cond = &visibility; // Every code is 11.

    assign defeat_cond = (strikes == 2'(`STRIKE_LIMIT)) ||
                         (difficulty && (timer >= 11'(`TIME_LIMIT_SECONDS)));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sudoku_game_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // Hard is 1, easy is 0.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            difficulty <= 1'b0;
        end else if (state == sudoku_game_pkg::select_level) begin
            if (buttons.up) begin
                difficulty <= 1'b1;
            end else if (buttons.down) begin
                difficulty <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state = state;

        case (state)
            sudoku_game_pkg::idle: begin
                if (buttons.start) begin
                    next_state = sudoku_game_pkg::select_level;
                end
            end
            sudoku_game_pkg::select_level: begin
                if (buttons.a) begin
                    next_state = sudoku_game_pkg::loading;
                end
            end
            sudoku_game_pkg::loading: begin
                if (|visibility) begin // Map has landed in the board registers.
                    next_state = sudoku_game_pkg::walk_map;
                end
            end
            sudoku_game_pkg::walk_map: begin
                if (buttons.a && !cell_revealed) begin
                    next_state = sudoku_game_pkg::pick_number;
                end
            end
            sudoku_game_pkg::pick_number: begin
                // A wrong guess stays here, the strike is counted by board_keeper.
                if ((buttons.a && (cell_value == candidate)) || buttons.b) begin
                    next_state = sudoku_game_pkg::walk_map;
                end
            end
            sudoku_game_pkg::victory,
            sudoku_game_pkg::defeat: begin
                if (buttons.start) begin
                    next_state = sudoku_game_pkg::select_level;
                end
            end
            default: begin
                next_state = sudoku_game_pkg::idle;
            end
        endcase

        if (playing && victory_cond) begin
            next_state = sudoku_game_pkg::victory;
        end

        // Defeat is checked last so it wins over victory.
        if (playing && defeat_cond) begin
            next_state = sudoku_game_pkg::defeat;
        end
    end

endmodule

// File: source/cursor_mover.sv
`timescale 1ns/1ps
`include "sudoku_params.svh"

module cursor_mover (
    input  logic                         clk,
    input  logic                         reset,
    input  sudoku_io_pkg::buttons_t      buttons,
    input  sudoku_game_pkg::game_state_t state,
    output sudoku_game_pkg::cell_pos_t   pos
);

    localparam logic [3:0] last_idx = 4'(`SUDOKU_N - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos <= '0;
        end else if (state == sudoku_game_pkg::walk_map) begin
            // One pulse at a time is expected, up and left take priority.
            if (buttons.up) begin
                pos.row <= (pos.row == 4'd0) ? last_idx : pos.row - 4'd1;
            end else if (buttons.down) begin
                pos.row <= (pos.row == last_idx) ? 4'd0 : pos.row + 4'd1;
            end

            if (buttons.left) begin
                pos.col <= (pos.col == 4'd0) ? last_idx : pos.col - 4'd1;
            end else if (buttons.right) begin
                pos.col <= (pos.col == last_idx) ? 4'd0 : pos.col + 4'd1;
            end
        end
    end

endmodule

// File: source/board_keeper.sv
`timescale 1ns/1ps
`include "sudoku_params.svh"

module board_keeper (
    input  logic                         clk,
    input  logic                         reset,
    input  sudoku_io_pkg::buttons_t      buttons,
    input  sudoku_game_pkg::game_state_t state,
    input  sudoku_game_pkg::cell_pos_t   pos,
    input  sudoku_game_pkg::board_t      selected_map,
    input  sudoku_game_pkg::visibility_t selected_visibility,
    output sudoku_game_pkg::board_t      board,
    output sudoku_game_pkg::visibility_t visibility,
    output logic [`CELL_W-1:0]           cell_value,
    output logic                         cell_revealed,
    output logic [`CELL_W-1:0]           candidate,
    output logic [1:0]                   strikes,
    output logic                         error
);

    localparam int index_w = $clog2(`SUDOKU_CELLS);
    localparam logic [`CELL_W-1:0] max_number = `CELL_W'(`SUDOKU_N);

    logic [index_w-1:0] cell_index;

    // Row-major cell number under the cursor.
    assign cell_index = index_w'(pos.row) * index_w'(`SUDOKU_N) + index_w'(pos.col);

    assign cell_value    = board[cell_index];
    assign cell_revealed = &visibility[cell_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board      <= '0;
            visibility <= '0;
            candidate  <= '0;
            strikes    <= 2'd0;
            error      <= 1'b0;
        end else begin
            error <= 1'b0; // Only high for the cycle after a wrong guess.

            case (state)
                sudoku_game_pkg::select_level: begin
                    // Start each round from an empty board so loading always
                    // waits for the fresh copy.
                    board      <= '0;
                    visibility <= '0;
                end
                sudoku_game_pkg::loading: begin
                    board      <= selected_map;
                    visibility <= selected_visibility;
                    strikes    <= 2'd0;
                    candidate  <= `CELL_W'(1);
                end
                sudoku_game_pkg::pick_number: begin
                    if (buttons.a) begin
                        if (candidate == cell_value) begin
                            visibility[cell_index] <= '1;
                        end else begin
                            strikes <= strikes + 2'd1;
                            error   <= 1'b1;
                        end
                    end else if (buttons.right) begin
                        candidate <= (candidate == max_number) ? `CELL_W'(1)
                                                               : candidate + `CELL_W'(1);
                    end else if (buttons.left) begin
                        candidate <= (candidate == `CELL_W'(1)) ? max_number
                                                                : candidate - `CELL_W'(1);
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: source/display_formatter.sv
`timescale 1ns/1ps
`include "sudoku_params.svh"

module display_formatter (
    input  sudoku_game_pkg::game_state_t state,
    input  sudoku_io_pkg::clock_time_t   clock_time,
    input  logic [6:0]                   score,
    input  logic [1:0]                   strikes,
    input  logic [`CELL_W-1:0]           candidate,
    input  logic [`CELL_W-1:0]           cell_value,
    input  logic                         cell_revealed,
    output sudoku_io_pkg::digits_t       digits
);

    logic playing;

    assign playing = (state == sudoku_game_pkg::walk_map) ||
                     (state == sudoku_game_pkg::pick_number);

    always_comb begin
        if (playing) begin
            // Only the minutes units fit, the tens digit is not shown.
            digits.d0 = 4'(clock_time.seconds % 6'd10);
            digits.d1 = 4'(clock_time.seconds / 6'd10);
            digits.d2 = 4'(clock_time.minutes % 5'd10);
        end else begin
            digits.d0 = 4'(score % 7'd10);
            digits.d1 = 4'((score / 7'd10) % 7'd10);
            digits.d2 = 4'(score / 7'd100);
        end

        digits.d3 = {2'b00, strikes};
        digits.d4 = 4'(candidate);
        digits.d5 = cell_revealed ? 4'(cell_value) : 4'd0; // Hidden cells show blank as 0.
    end

endmodule

// File: source/sudoku_top.sv
`timescale 1ns/1ps
`include "sudoku_params.svh"

module sudoku_top (
    input  logic                         clk,
    input  logic                         reset,
    input  sudoku_io_pkg::buttons_t      buttons,
    input  logic [10:0]                  timer,
    input  sudoku_io_pkg::clock_time_t   clock_time,
    input  logic [6:0]                   score,
    input  sudoku_game_pkg::board_t      selected_map,
    input  sudoku_game_pkg::visibility_t selected_visibility,
    output sudoku_game_pkg::game_state_t state,
    output logic                         difficulty,
    output logic [1:0]                   strikes,
    output sudoku_game_pkg::cell_pos_t   pos,
    output logic                         error,
    output sudoku_io_pkg::digits_t       digits,
    output sudoku_game_pkg::board_t      board,
    output sudoku_game_pkg::visibility_t visibility
);

    logic [`CELL_W-1:0] candidate;
    logic [`CELL_W-1:0] cell_value;
    logic               cell_revealed;

    game_fsm game_fsm_inst (
        .clk           (clk),
        .reset         (reset),
        .buttons       (buttons),
        .visibility    (visibility),
        .cell_revealed (cell_revealed),
        .cell_value    (cell_value),
        .candidate     (candidate),
        .strikes       (strikes),
        .timer         (timer),
        .state         (state),
        .difficulty    (difficulty)
    );

    cursor_mover cursor_mover_inst (
        .clk     (clk),
        .reset   (reset),
        .buttons (buttons),
        .state   (state),
        .pos     (pos)
    );

    board_keeper board_keeper_inst (
        .clk                 (clk),
        .reset               (reset),
        .buttons             (buttons),
        .state               (state),
        .pos                 (pos),
        .selected_map        (selected_map),
        .selected_visibility (selected_visibility),
        .board               (board),
        .visibility          (visibility),
        .cell_value          (cell_value),
        .cell_revealed       (cell_revealed),
        .candidate           (candidate),
        .strikes             (strikes),
        .error               (error)
    );

    display_formatter display_formatter_inst (
        .state         (state),
        .clock_time    (clock_time),
        .score         (score),
        .strikes       (strikes),
        .candidate     (candidate),
        .cell_value    (cell_value),
        .cell_revealed (cell_revealed),
        .digits        (digits)
    );

endmodule

// File: bench/tb_sudoku.sv
`timescale 1ns/1ps

module tb_sudoku;

    localparam int cells = 81;
    localparam logic [6:0] btn_none  = 7'b0000000;
    localparam logic [6:0] btn_up    = 7'b1000000;
    localparam logic [6:0] btn_down  = 7'b0100000;
    localparam logic [6:0] btn_left  = 7'b0010000;
    localparam logic [6:0] btn_right = 7'b0001000;
    localparam logic [6:0] btn_start = 7'b0000100;
    localparam logic [6:0] btn_a     = 7'b0000010;
    localparam logic [6:0] btn_b     = 7'b0000001;
    localparam logic [5:0] clock_seconds = 6'd42;
    localparam logic [4:0] clock_minutes = 5'd3;

    // One row of the table holds the stimulus and then what the DUT must show.
    typedef struct packed {
        logic [6:0]                   btn;
        logic [10:0]                  timer;
        logic [6:0]                   score;
        sudoku_game_pkg::game_state_t state;
        logic                         difficulty;
        logic [1:0]                   strikes;
        logic                         error;
        sudoku_game_pkg::cell_pos_t   pos;
        sudoku_io_pkg::digits_t       digits;
        sudoku_game_pkg::board_t      board;
        sudoku_game_pkg::visibility_t visibility;
        logic [3:0]                   test;
    } step_t;

    logic                         clk;
    logic                         reset;
    sudoku_io_pkg::buttons_t      buttons;
    logic [10:0]                  timer;
    sudoku_io_pkg::clock_time_t   clock_time;
    logic [6:0]                   score;
    sudoku_game_pkg::board_t      selected_map;
    sudoku_game_pkg::visibility_t selected_visibility;
    sudoku_game_pkg::game_state_t state;
    logic                         difficulty;
    logic [1:0]                   strikes;
    sudoku_game_pkg::cell_pos_t   pos;
    logic                         error;
    sudoku_io_pkg::digits_t       digits;
    sudoku_game_pkg::board_t      board;
    sudoku_game_pkg::visibility_t visibility;

    step_t steps[$];
    logic [7:0] lfsr;
    sudoku_game_pkg::board_t m_board;
    sudoku_game_pkg::visibility_t m_vis; // Reference model of the visibility codes.
    sudoku_game_pkg::game_state_t m_state;
    sudoku_game_pkg::cell_pos_t m_pos;
    logic m_diff;
    logic [1:0] m_strikes;
    logic [3:0] m_cand;
    logic [10:0] cur_timer;
    logic [6:0] cur_score;
    int cur_test;
    int errors = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit table_ready = 1'b0;

    sudoku_top sudoku_top_inst (
        .clk                 (clk),
        .reset               (reset),
        .buttons             (buttons),
        .timer               (timer),
        .clock_time          (clock_time),
        .score               (score),
        .selected_map        (selected_map),
        .selected_visibility (selected_visibility),
        .state               (state),
        .difficulty          (difficulty),
        .strikes             (strikes),
        .pos                 (pos),
        .error               (error),
        .digits              (digits),
        .board               (board),
        .visibility          (visibility)
    );

    always #50 clk = ~clk;

    // Taps for x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
        lfsr = {lfsr[6:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] random_digit();
        logic [3:0] raw;
        int i;
        raw = '0;
        for (i = 0; i < 4; i++) raw = {raw[2:0], lfsr_bit()};
        return 4'(raw % 4'd9) + 4'd1;
    endfunction

    function automatic int cursor_index();
        return m_pos.row * 9 + m_pos.col;
    endfunction

    function automatic sudoku_io_pkg::digits_t expect_digits(sudoku_game_pkg::game_state_t st);
        sudoku_io_pkg::digits_t d;
        if (st == sudoku_game_pkg::walk_map || st == sudoku_game_pkg::pick_number) begin
            d.d0 = 4'(clock_seconds % 10);
            d.d1 = 4'(clock_seconds / 10);
            d.d2 = 4'(clock_minutes % 10);
        end else begin
            d.d0 = 4'(cur_score % 10);
            d.d1 = 4'((cur_score / 10) % 10);
            d.d2 = 4'(cur_score / 100);
        end
        d.d3 = {2'b00, m_strikes};
        d.d4 = m_cand;
        d.d5 = (&m_vis[cursor_index()]) ? selected_map[cursor_index()] : 4'd0;
        return d;
    endfunction

    // Applies one button to the model and records the expected response.
    task automatic add_step(input logic [6:0] btn, input sudoku_game_pkg::game_state_t next);
        sudoku_io_pkg::buttons_t b;
        step_t s;
        logic err;
        b = btn;
        err = 1'b0;
        case (m_state)
            sudoku_game_pkg::select_level: begin
                m_board = '0;
                m_vis = '0;
                if (b.up) begin
                    m_diff = 1'b1;
                end else if (b.down) begin
                    m_diff = 1'b0;
                end
            end
            sudoku_game_pkg::loading: begin
                m_board = selected_map;
                m_vis = selected_visibility;
                m_strikes = 2'd0;
                m_cand = 4'd1;
            end
            sudoku_game_pkg::walk_map: begin
                if (b.up) m_pos.row = (m_pos.row == 4'd0) ? 4'd8 : m_pos.row - 4'd1;
                if (b.down) m_pos.row = (m_pos.row == 4'd8) ? 4'd0 : m_pos.row + 4'd1;
                if (b.left) m_pos.col = (m_pos.col == 4'd0) ? 4'd8 : m_pos.col - 4'd1;
                if (b.right) m_pos.col = (m_pos.col == 4'd8) ? 4'd0 : m_pos.col + 4'd1;
            end
            sudoku_game_pkg::pick_number: begin
                if (b.a && m_cand == selected_map[cursor_index()]) begin
                    m_vis[cursor_index()] = 2'b11;
                end else if (b.a) begin
                    m_strikes = m_strikes + 2'd1;
                    err = 1'b1;
                end else if (b.right) begin
                    m_cand = (m_cand == 4'd9) ? 4'd1 : m_cand + 4'd1;
                end else if (b.left) begin
                    m_cand = (m_cand == 4'd1) ? 4'd9 : m_cand - 4'd1;
                end
            end
            default: ;
        endcase
        m_state = next;
        s.btn = btn;
        s.timer = cur_timer;
        s.score = cur_score;
        s.state = next;
        s.difficulty = m_diff;
        s.strikes = m_strikes;
        s.error = err;
        s.pos = m_pos;
        s.digits = expect_digits(next);
        s.board = m_board;
        s.visibility = m_vis;
        s.test = 4'(cur_test);
        steps.push_back(s);
    endtask

    task automatic start_round(input logic [6:0] level_btn);
        add_step(level_btn, sudoku_game_pkg::select_level);
        add_step(btn_a, sudoku_game_pkg::loading);
        add_step(btn_none, sudoku_game_pkg::loading); // Map is copied on this edge.
        add_step(btn_none, sudoku_game_pkg::walk_map);
    endtask

    task automatic solve_cell();
        add_step(btn_a, sudoku_game_pkg::pick_number);
        while (m_cand != selected_map[cursor_index()]) begin
            add_step(btn_right, sudoku_game_pkg::pick_number);
        end
        add_step(btn_a, sudoku_game_pkg::walk_map);
    endtask

    task automatic wrong_guess();
        if (m_cand == selected_map[cursor_index()]) begin
            add_step(btn_right, sudoku_game_pkg::pick_number);
        end
        add_step(btn_a, sudoku_game_pkg::pick_number);
    endtask

    task automatic build_table();
        cur_test = 1;
        add_step(btn_none, sudoku_game_pkg::idle);
        add_step(btn_start, sudoku_game_pkg::select_level);
        start_round(btn_up);
        cur_test = 2;
        add_step(btn_left, sudoku_game_pkg::walk_map);  // Column 0 wraps to 8 onto a hidden cell.
        add_step(btn_up, sudoku_game_pkg::walk_map);
        add_step(btn_down, sudoku_game_pkg::walk_map);  // Row 8 wraps to 0.
        add_step(btn_right, sudoku_game_pkg::walk_map);
        add_step(btn_a, sudoku_game_pkg::walk_map);     // A revealed cell opens no number entry.
        add_step(btn_left, sudoku_game_pkg::walk_map);
        cur_test = 3;
        add_step(btn_a, sudoku_game_pkg::pick_number);
        add_step(btn_right, sudoku_game_pkg::pick_number);
        add_step(btn_left, sudoku_game_pkg::pick_number);
        add_step(btn_left, sudoku_game_pkg::pick_number);
        add_step(btn_right, sudoku_game_pkg::pick_number);
        add_step(btn_b, sudoku_game_pkg::walk_map);
        cur_test = 4;
        add_step(btn_a, sudoku_game_pkg::pick_number);
        repeat (3) wrong_guess();
        cur_score = 7'd123;
        add_step(btn_none, sudoku_game_pkg::defeat);
        cur_test = 5;
        add_step(btn_start, sudoku_game_pkg::select_level);
        start_round(btn_down);
        cur_timer = 11'd300; // Past the limit, but easy ignores it.
        add_step(btn_none, sudoku_game_pkg::walk_map);
        solve_cell();
        add_step(btn_down, sudoku_game_pkg::walk_map);
        solve_cell();
        add_step(btn_up, sudoku_game_pkg::walk_map);
        add_step(btn_up, sudoku_game_pkg::walk_map);
        solve_cell();
        add_step(btn_none, sudoku_game_pkg::victory);
        add_step(btn_start, sudoku_game_pkg::select_level);
        cur_test = 6;
        cur_timer = 11'd0;
        start_round(btn_up);
        cur_timer = 11'd300;
        add_step(btn_none, sudoku_game_pkg::defeat);
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_state(input sudoku_game_pkg::game_state_t got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: state got %s expected %s",
                     $time, got.name(), exp.name());
            note_error();
        end
    endtask

    task automatic check_pos(input sudoku_game_pkg::cell_pos_t got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: pos got (%0d,%0d) expected (%0d,%0d)",
                     $time, got.row, got.col, exp.row, exp.col);
            note_error();
        end
    endtask

    task automatic check_digits(input sudoku_io_pkg::digits_t got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: digits got %h expected %h", $time, got, exp);
            note_error();
        end
    endtask

    task automatic check_count(input string name, input logic [1:0] got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0b expected %0b", $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_board(input sudoku_game_pkg::board_t got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: board got %h expected %h", $time, got, exp);
            note_error();
        end
    endtask

    task automatic check_visibility(input sudoku_game_pkg::visibility_t got, exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: visibility got %h expected %h", $time, got, exp);
            note_error();
        end
    endtask

    task automatic report_test(input int id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d: passed", id);
        end else begin
            tests_failed++;
            $display("Test %0d: failed with %0d mismatches", id, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        step_t s;
        int last_test;
        int k;
        clk = 1'b0;
        reset = 1'b1;
        buttons = '0;
        timer = '0;
        score = '0;
        clock_time = {clock_minutes, clock_seconds};
        lfsr = 8'd36;
        for (k = 0; k < cells; k++) begin
            selected_map[k] = random_digit();
            selected_visibility[k] = 2'b11;
        end
        selected_visibility[8] = 2'b00;  // Three hidden cells, with every
        selected_visibility[17] = 2'b01; // code that is not fully set.
        selected_visibility[80] = 2'b10;
        m_state = sudoku_game_pkg::idle;
        m_pos = '0;
        m_diff = 1'b0;
        m_strikes = 2'd0;
        m_cand = 4'd0;
        m_board = '0;
        m_vis = '0;
        cur_timer = 11'd0;
        cur_score = 7'd0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #10 reset = 1'b0;
        last_test = steps[0].test;
        foreach (steps[i]) begin
            s = steps[i];
            if (s.test != last_test) begin
                report_test(last_test);
                last_test = s.test;
            end
            buttons = s.btn;
            timer = s.timer;
            score = s.score;
            @(posedge clk);
            #10;
            check_state(state, s.state);
            check_flag("difficulty", difficulty, s.difficulty);
            check_count("strikes", strikes, s.strikes);
            check_flag("error", error, s.error);
            check_pos(pos, s.pos);
            check_digits(digits, s.digits);
            check_board(board, s.board);
            check_visibility(visibility, s.visibility);
        end
        report_test(last_test);
        $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Each step needs one cycle, so three per step is ample.
    initial begin
        wait (table_ready);
        #((steps.size() * 3 + 4) * 100);
        $display("Watchdog expired before all table steps were applied");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/sudoku_game_pkg.sv
source/sudoku_io_pkg.sv
source/game_fsm.sv
source/cursor_mover.sv
source/board_keeper.sv
source/display_formatter.sv
source/sudoku_top.sv
bench/tb_sudoku.sv

// File: Bender.yml
package:
  name: sudoku_game

sources:
  - include_dirs:
      - source
    files:
      - source/sudoku_game_pkg.sv
      - source/sudoku_io_pkg.sv
      - source/game_fsm.sv
      - source/cursor_mover.sv
      - source/board_keeper.sv
      - source/display_formatter.sv
      - source/sudoku_top.sv
  - target: test
    files:
      - bench/tb_sudoku.sv
